// File: mic_meter_macros.svh
`ifndef MIC_METER_MACROS_SVH
`define MIC_METER_MACROS_SVH

//------------------------------------------------------------
// Clocking

`define CLK_MHZ          50   // Board oscillator
`define MIC_SCK_DIV      4    // clk cycles per half sck
`define TM_BIT_DIV       4    // clk cycles per half tm_clk

//------------------------------------------------------------
// Widths and counts

`define MIC_W_SAMPLE     24   // INMP441 word width
`define W_LED            8    // TM1638 LED row
`define W_KEY            8    // TM1638 keys
`define W_BOARD_KEY      2    // Onboard push buttons
`define W_DIGIT          8    // Seven-segment digits

//------------------------------------------------------------
// Level meter

`define WINDOW_SAMPLES   16   // Samples per peak window

`endif

// File: mic_meter_pkg.sv
`include "mic_meter_macros.svh"

package mic_meter_pkg;

    //------------------------------------------------------------
    // Seven-segment coding, bit a in the MSB, dp off

    function automatic logic [7:0] hex_to_segments (input logic [3:0] nibble);
        logic [7:0] abcdefgh;
        case (nibble)
            4'h0: abcdefgh = 8'hFC;
            4'h1: abcdefgh = 8'h60;
            4'h2: abcdefgh = 8'hDA;
            4'h3: abcdefgh = 8'hF2;
            4'h4: abcdefgh = 8'h66;
            4'h5: abcdefgh = 8'hB6;
            4'h6: abcdefgh = 8'hBE;
            4'h7: abcdefgh = 8'hE0;
            4'h8: abcdefgh = 8'hFE;
            4'h9: abcdefgh = 8'hF6;
            4'hA: abcdefgh = 8'hEE;
            4'hB: abcdefgh = 8'h3E;   // Lower case b
            4'hC: abcdefgh = 8'h9C;
            4'hD: abcdefgh = 8'h7A;   // Lower case d
            4'hE: abcdefgh = 8'h9E;
            default: abcdefgh = 8'h8E;
        endcase
        return abcdefgh;
    endfunction

    // Index of highest set bit plus one
    function automatic logic [4:0] bit_length (input logic [`MIC_W_SAMPLE - 1:0] value);
        logic [4:0] len;
        len = '0;
        for (int i = 0; i < `MIC_W_SAMPLE; i++)
            if (value [i])
                len = 5' (i + 1);       // Last hit wins
        return len;
    endfunction

    // Thermometer bar, one LED per 3 bits of level
    function automatic logic [`W_LED - 1:0] bar_leds (input logic [4:0] len);
        logic [4:0]          lit;
        logic [`W_LED - 1:0] bar;
        lit = len / 5'd3;
        if (lit > 5' (`W_LED))
            lit = 5' (`W_LED);        // Saturate at full row
        for (int i = 0; i < `W_LED; i++)
            bar [i] = i < lit;          // Fill from bit 0
        return bar;
    endfunction

endpackage

// File: display_if.sv
`timescale 1ns/1ps
`include "mic_meter_macros.svh"

interface display_if;

    logic [`W_DIGIT - 1:0][7:0] seg;          // abcdefgh per digit, digit 0 rightmost
    logic [`W_LED   - 1:0]      led;          // LED row, bit 0 first
    logic [`W_KEY   - 1:0]      keys;         // Key byte from last read frame
    logic                       keys_strobe;  // One cycle on keys update

    // Display producer side
    modport meter
    (
        output seg,
        output led,
        input  keys,
        input  keys_strobe
    );

    // Serial bus side
    modport ctl
    (
        input  seg,
        input  led,
        output keys,
        output keys_strobe
    );

endinterface

// File: i2s_mic_receiver.sv
`timescale 1ns/1ps
`include "mic_meter_macros.svh"

module i2s_mic_receiver
(
    input                               clk,
    input                               rst,
    output logic                        mic_sck,
    output                              mic_ws,
    output                              mic_lr,
    input                               mic_sd,
    output        [`MIC_W_SAMPLE - 1:0] sample,
    output logic                        sample_valid
);

    localparam w_div = $clog2 (`MIC_SCK_DIV + 1);

    //------------------------------------------------------------
    // Bit clock and frame position

    logic [w_div - 1:0]         div_cnt;       // clk cycles within half sck
    logic [5:0]                 bit_cnt;       // sck period within frame
    logic [`MIC_W_SAMPLE - 1:0] shift;         // Left word, MSB first

    wire half_end = div_cnt == w_div' (`MIC_SCK_DIV - 1);
    wire sck_rise = half_end & ~mic_sck;
    wire sck_fall = half_end &  mic_sck;

    // Left word occupies periods 1..24, one period after ws edge
    wire capture  = sck_rise
                    && bit_cnt >= 6'd1
                    && bit_cnt <= 6' (`MIC_W_SAMPLE);
    wire last_bit = sck_rise && bit_cnt == 6' (`MIC_W_SAMPLE);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            div_cnt      <= '0;
            mic_sck      <= 1'b0;
            bit_cnt      <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            div_cnt      <= half_end ? '0 : div_cnt + 1'b1;
            sample_valid <= last_bit;           // Single pulse per frame

            if (half_end)
                mic_sck <= ~mic_sck;

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;      // Wraps every 64 periods
        end
    end

    //------------------------------------------------------------
    // Data capture

    always_ff @(posedge clk)
    begin
        if (capture)
            shift <= {shift [`MIC_W_SAMPLE - 2:0], mic_sd};
    end

    assign sample = shift;                      // Stable outside left slot
    assign mic_ws = bit_cnt [5];                // Low for left half
    assign mic_lr = 1'b0;                       // Mic strapped to left channel

endmodule

// File: level_meter.sv
`timescale 1ns/1ps
`include "mic_meter_macros.svh"

module level_meter
(
    input                               clk,
    input                               rst,
    input         [`MIC_W_SAMPLE - 1:0] sample,
    input                               sample_valid,
    display_if.meter                    disp
);

    localparam w_win = $clog2 (`WINDOW_SAMPLES);

    logic [`MIC_W_SAMPLE - 1:0] mag;            // Absolute sample value
    logic                       mag_valid;
    logic [`MIC_W_SAMPLE - 1:0] run_peak;       // Max within current window
    logic [`MIC_W_SAMPLE - 1:0] shown_peak;     // Published, frozen on hold
    logic [w_win - 1:0]         win_cnt;
    logic [`W_KEY - 1:0]        key_code;       // Latched key byte

    wire [`MIC_W_SAMPLE - 1:0] new_peak = mag > run_peak ? mag : run_peak;
    wire                       hold     = disp.keys [0];
    wire                       win_last = win_cnt == w_win' (`WINDOW_SAMPLES - 1);

    //------------------------------------------------------------
    // Magnitude stage

    always_ff @(posedge clk)
    begin
        if (sample_valid)
            mag <= sample [`MIC_W_SAMPLE - 1] ? ~sample + 1'b1 : sample;
    end

    //------------------------------------------------------------
    // Window peak

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mag_valid  <= 1'b0;
            run_peak   <= '0;
            shown_peak <= '0;
            win_cnt    <= '0;
        end
        else
        begin
            mag_valid <= sample_valid;

            if (mag_valid)
            begin
                if (win_last)
                begin
                    run_peak <= '0;             // Fresh window
                    win_cnt  <= '0;
                    if (~hold)
                        shown_peak <= new_peak;
                end
                else
                begin
                    run_peak <= new_peak;
                    win_cnt  <= win_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            key_code <= '0;
        else if (disp.keys_strobe)
            key_code <= disp.keys;              // Only on fresh read
    end

    //------------------------------------------------------------
    // Display patterns

    always_comb
    begin
        for (int i = 0; i < `MIC_W_SAMPLE / 4; i++)
            disp.seg [i] = mic_meter_pkg::hex_to_segments (shown_peak [4 * i +: 4]);

        // Two leftmost digits show the key code
        disp.seg [`W_DIGIT - 2] = mic_meter_pkg::hex_to_segments (key_code [3:0]);
        disp.seg [`W_DIGIT - 1] = mic_meter_pkg::hex_to_segments (key_code [7:4]);

        disp.led = mic_meter_pkg::bar_leds (mic_meter_pkg::bit_length (shown_peak));
    end

endmodule

// File: tm1638_controller.sv
`timescale 1ns/1ps
`include "mic_meter_macros.svh"

module tm1638_controller
(
    input               clk,
    input               rst,
    display_if.ctl      disp,
    output logic        tm_stb,
    output logic        tm_clk,
    output logic        tm_dio_out,
    output logic        tm_dio_oe,
    input               tm_dio_in
);

    //------------------------------------------------------------
    // Byte positions within a refresh frame

    localparam logic [4:0] pos_data_cmd = 5'd0,   // 0x40 alone
                           pos_addr_cmd = 5'd1,   // 0xC0, then display data
                           pos_data_0   = 5'd2,
                           pos_data_end = 5'd17,
                           pos_ctrl_cmd = 5'd18,  // 0x8F alone
                           pos_read_cmd = 5'd19,  // 0x42, then key reads
                           pos_read_0   = 5'd20,
                           pos_last     = 5'd23;

    localparam w_div = $clog2 (`TM_BIT_DIV + 1);

    typedef enum logic [1:0]
    {
        st_gap,                                   // stb high between groups
        st_stb,                                   // stb low, clk still high
        st_clk_lo,
        st_clk_hi
    } state_t;

    state_t                     state;
    logic [w_div - 1:0]         div_cnt;          // Half-bit timer
    logic [4:0]                 pos;              // Current byte in frame
    logic [2:0]                 bit_cnt;
    logic [7:0]                 shift;            // Outgoing byte, LSB first
    logic [7:0]                 rx;               // Incoming byte, LSB first
    logic [5:0]                 key_acc;          // Keys from reads 0..2
    logic [`W_DIGIT - 1:0][7:0] seg_snap;         // Frame-start copy
    logic [`W_LED - 1:0]        led_snap;
    logic [7:0]                 load_byte;        // Next byte to shift out
    logic [4:0]                 data_idx;

    wire       tick      = div_cnt == w_div' (`TM_BIT_DIV - 1);
    wire       is_read   = pos >= pos_read_0;
    wire       group_end = pos == pos_data_cmd || pos == pos_data_end
                           || pos == pos_ctrl_cmd || pos == pos_last;
    wire [7:0] rx_next   = {tm_dio_in, rx [7:1]};
    wire [4:0] load_pos  = state == st_gap ? pos : pos + 1'b1;

    //------------------------------------------------------------
    // Byte selection

    always_comb
    begin
        data_idx = load_pos - pos_data_0;         // Even seg, odd LED
        case (load_pos)
            pos_data_cmd: load_byte = 8'h40;      // Write, auto increment
            pos_addr_cmd: load_byte = 8'hC0;      // Start at address 0
            pos_ctrl_cmd: load_byte = 8'h8F;      // Display on, max brightness
            pos_read_cmd: load_byte = 8'h42;      // Read key scan
            default:
            begin
                if (load_pos <= pos_data_end)
                    load_byte = data_idx [0] ? {7'b0, led_snap [data_idx [3:1]]}
                                             : seg_snap [data_idx [3:1]];
                else
                    load_byte = 8'h00;            // Read slot, dio released
            end
        endcase
    end

    //------------------------------------------------------------
    // Frame FSM

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state            <= st_gap;
            div_cnt          <= '0;
            pos              <= '0;
            bit_cnt          <= '0;
            disp.keys        <= '0;
            disp.keys_strobe <= 1'b0;
        end
        else
        begin
            div_cnt          <= tick ? '0 : div_cnt + 1'b1;
            disp.keys_strobe <= 1'b0;

            if (tick)
            begin
                case (state)
                    st_gap:
                    begin
                        if (pos == pos_data_cmd)
                        begin
                            seg_snap <= disp.seg;         // New frame
                            led_snap <= disp.led;
                        end
                        shift <= load_byte;
                        state <= st_stb;
                    end
                    st_stb:    state <= st_clk_lo;
                    st_clk_lo: state <= st_clk_hi;
                    st_clk_hi:
                    begin
                        rx      <= rx_next;
                        bit_cnt <= bit_cnt + 1'b1;        // Wraps after bit 7
                        shift   <= shift >> 1;
                        state   <= st_clk_lo;

                        if (bit_cnt == 3'd7)
                        begin
                            if (pos == pos_last)
                            begin
                                disp.keys        <= {rx_next [4], rx_next [0], key_acc};
                                disp.keys_strobe <= 1'b1;
                            end
                            else if (is_read)
                            begin
                                key_acc [2 * pos [1:0]]     <= rx_next [0];
                                key_acc [2 * pos [1:0] + 1] <= rx_next [4];
                            end

                            pos <= pos == pos_last ? '0 : pos + 1'b1;

                            if (group_end)
                                state <= st_gap;          // Raise stb
                            else
                                shift <= load_byte;       // Next byte, same group
                        end
                    end
                    default: state <= st_gap;
                endcase
            end
        end
    end

    //------------------------------------------------------------
    // Pin registers, one cycle behind the FSM

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tm_stb    <= 1'b1;
            tm_clk    <= 1'b1;
            tm_dio_oe <= 1'b0;
        end
        else
        begin
            tm_stb    <= state == st_gap;
            tm_clk    <= state != st_clk_lo;
            tm_dio_oe <= state != st_gap && !is_read;
        end
    end

    always_ff @(posedge clk)
    begin
        tm_dio_out <= shift [0];                  // Changes with falling tm_clk
    end

endmodule

// File: board_top.sv
`timescale 1ns/1ps
`include "mic_meter_macros.svh"

module board_top
(
    input                        clk,
    input                        rst,

    input  [`W_BOARD_KEY - 1:0]  key,          // Active low buttons
    input  [1:0]                 sw,           // Reserved
    output [`W_LED - 1:0]        led,

    output                       mic_sck,
    output                       mic_ws,
    output                       mic_lr,
    input                        mic_sd,

    output                       tm_stb,
    output                       tm_clk,
    output                       tm_dio_out,
    output                       tm_dio_oe,
    input                        tm_dio_in
);

    //------------------------------------------------------------

    wire [`MIC_W_SAMPLE - 1:0] sample;
    wire                       sample_valid;

    display_if meter_bus ();                   // Meter view, merged keys
    display_if tm_bus    ();                   // Controller view

    // Board buttons share the low key bits with the TM1638 keys
    assign meter_bus.keys        = tm_bus.keys
                                   | {{(`W_KEY - `W_BOARD_KEY) {1'b0}}, ~key};
    assign meter_bus.keys_strobe = tm_bus.keys_strobe;

    assign tm_bus.seg = meter_bus.seg;
    assign tm_bus.led = meter_bus.led;
    assign led        = meter_bus.led;         // Onboard LEDs mirror the bar

    //------------------------------------------------------------

    i2s_mic_receiver i_mic
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .mic_sck      ( mic_sck      ),
        .mic_ws       ( mic_ws       ),
        .mic_lr       ( mic_lr       ),
        .mic_sd       ( mic_sd       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    level_meter i_meter
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid ),
        .disp         ( meter_bus    )
    );

    tm1638_controller i_ledkey
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .disp         ( tm_bus       ),
        .tm_stb       ( tm_stb       ),
        .tm_clk       ( tm_clk       ),
        .tm_dio_out   ( tm_dio_out   ),
        .tm_dio_oe    ( tm_dio_oe    ),
        .tm_dio_in    ( tm_dio_in    )
    );

endmodule

// File: board_top_assert.sv
`timescale 1ns/1ps

module board_top_assert
(
    input clk,
    input rst,
    input tm_stb,
    input tm_clk,
    input tm_dio_oe,
    input keys_strobe
);

    int unsigned fail_count = 0;                // Failed property count

    //------------------------------------------------------------
    // TM1638 serial bus

    // Chip owns nothing while deselected
    oe_when_idle: assert property (@(posedge clk) disable iff (rst) tm_stb |-> !tm_dio_oe)
    else
    begin
        fail_count++;
        $error("tm_dio_oe is active while tm_stb is high");
    end

    // Clock parked high between groups
    clk_when_idle: assert property (@(posedge clk) disable iff (rst) tm_stb |-> tm_clk)
    else
    begin
        fail_count++;
        $error("tm_clk is low while tm_stb is high");
    end

    //------------------------------------------------------------
    // Key update pulse

    strobe_single: assert property (@(posedge clk) disable iff (rst) keys_strobe |=> !keys_strobe)
    else
    begin
        fail_count++;
        $error("keys_strobe stayed high for more than one cycle");
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // 8 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (8) @(posedge clk);              // Eight cycles in reset
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: tb_board_top.sv
`timescale 1ns/1ps
`include "mic_meter_macros.svh"

module tb_board_top;

    logic                      clk;
    logic                      rst;
    logic [`W_BOARD_KEY - 1:0] key;
    logic [1:0]                sw;
    logic                      mic_sd    = 1'b0;
    logic                      tm_dio_in = 1'b0;
    wire  [`W_LED - 1:0]       led;
    wire                       mic_sck, mic_ws, mic_lr;
    wire                       tm_stb, tm_clk, tm_dio_out, tm_dio_oe;

    int          errors;                        // Value mismatches
    int          timeouts;
    int          assert_fails;
    int unsigned seed;

    tb_clock_gen clk_gen0 (.clk (clk), .rst (rst));

    board_top dut0
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .key        ( key        ),
        .sw         ( sw         ),
        .led        ( led        ),
        .mic_sck    ( mic_sck    ),
        .mic_ws     ( mic_ws     ),
        .mic_lr     ( mic_lr     ),
        .mic_sd     ( mic_sd     ),
        .tm_stb     ( tm_stb     ),
        .tm_clk     ( tm_clk     ),
        .tm_dio_out ( tm_dio_out ),
        .tm_dio_oe  ( tm_dio_oe  ),
        .tm_dio_in  ( tm_dio_in  )
    );

    bind tm1638_controller board_top_assert bus_check
    (
        .clk         ( clk              ),
        .rst         ( rst              ),
        .tm_stb      ( tm_stb           ),
        .tm_clk      ( tm_clk           ),
        .tm_dio_oe   ( tm_dio_oe        ),
        .keys_strobe ( disp.keys_strobe )
    );

    //------------------------------------------------------------
    // INMP441 model driving the left slot only

    logic [23:0] mic_queue [$];                 // Words for coming frames
    logic [23:0] mic_word;
    logic [23:0] mic_idle;                      // Sent once the queue is empty
    int          mic_pos;                       // sck period since ws fell
    int          mic_sent;                      // Words started since reset
    logic        sck_prev = 1'b0;
    logic        ws_prev  = 1'b0;

    always @(negedge clk)
    begin
        if (rst)
        begin
            mic_pos  = 0;
            mic_sent = 0;
            mic_sd   = 1'b0;
        end
        else if (sck_prev && !mic_sck)          // Falling sck
        begin
            mic_pos = (ws_prev && !mic_ws) ? 0 : mic_pos + 1;
            if (mic_pos == 1)
            begin
                if (mic_queue.size () > 0)
                    mic_word = mic_queue.pop_front ();
                else
                    mic_word = mic_idle;
                mic_sent++;
            end
            mic_sd = (mic_pos >= 1 && mic_pos <= 24) ? mic_word [24 - mic_pos] : 1'b0;
        end
        sck_prev = mic_sck;
        ws_prev  = mic_ws;
    end

    //------------------------------------------------------------
    // TM1638 model

    logic [7:0] tm_bytes [16];                  // Display RAM image
    logic [7:0] tm_rx;
    logic [7:0] tm_cmd;                         // First byte of the group
    logic [7:0] tm_keys;                        // Pressed keys with one bit per key
    logic       tm_oe_exp;                      // Controller owns dio outside key reads
    int         tm_bits;
    int         tm_nbytes;                      // Bytes in current group
    int         tm_frames;                      // Finished refreshes
    logic       tm_clk_prev = 1'b1;
    logic       tm_stb_prev = 1'b1;

    function automatic int group_length (input logic [7:0] cmd);
        case (cmd)
            8'h40, 8'h8F: return 1;
            8'hC0:        return 17;            // Address plus 16 data
            8'h42:        return 5;             // Command plus 4 key bytes
            default:      return -1;
        endcase
    endfunction

    always @(negedge clk)
    begin
        if (rst)
        begin
            tm_bits   = 0;
            tm_nbytes = 0;
            tm_frames = 0;
        end
        else if (!tm_stb)
        begin
            if (!tm_clk_prev && tm_clk)         // Rising tm_clk shifts LSB first
            begin
                tm_oe_exp = !(tm_cmd == 8'h42 && tm_nbytes > 0);
                assert (tm_dio_oe === tm_oe_exp)
                else
                begin
                    errors++;
                    $display("FAIL tm_dio_oe got %h expected %h", tm_dio_oe, tm_oe_exp);
                end
                tm_rx = {tm_dio_out, tm_rx [7:1]};
                tm_bits++;
                if (tm_bits == 8)
                begin
                    if (tm_nbytes == 0)
                        tm_cmd = tm_rx;
                    else if (tm_cmd == 8'hC0 && tm_nbytes <= 16)
                        tm_bytes [tm_nbytes - 1] = tm_rx;
                    tm_bits = 0;
                    tm_nbytes++;
                end
            end
            else if (tm_clk_prev && !tm_clk && tm_nbytes > 0 && tm_cmd == 8'h42)
                tm_dio_in = tm_bits == 0 ? tm_keys [2 * (tm_nbytes - 1)]
                          : tm_bits == 4 ? tm_keys [2 * tm_nbytes - 1] : 1'b0;
        end
        else if (!tm_stb_prev)                  // Group just closed
        begin
            assert (tm_nbytes == group_length (tm_cmd))
            else
            begin
                errors++;
                $display("FAIL tm_dio_out group %h byte count got %h expected %h",
                         tm_cmd, tm_nbytes, group_length (tm_cmd));
            end
            if (tm_cmd == 8'h42)
                tm_frames++;
            tm_bits   = 0;
            tm_nbytes = 0;
        end
        tm_clk_prev = tm_clk;
        tm_stb_prev = tm_stb;
    end

    //------------------------------------------------------------
    // Reference model

    function automatic logic [3:0] segments_to_nibble (input logic [7:0] pattern);
        case (pattern)
            8'hFC: return 4'h0;
            8'h60: return 4'h1;
            8'hDA: return 4'h2;
            8'hF2: return 4'h3;
            8'h66: return 4'h4;
            8'hB6: return 4'h5;
            8'hBE: return 4'h6;
            8'hE0: return 4'h7;
            8'hFE: return 4'h8;
            8'hF6: return 4'h9;
            8'hEE: return 4'hA;
            8'h3E: return 4'hB;
            8'h9C: return 4'hC;
            8'h7A: return 4'hD;
            8'h9E: return 4'hE;
            8'h8E: return 4'hF;
            default: return 4'hx;               // Not a hex glyph
        endcase
    endfunction

    function automatic logic [23:0] magnitude (input logic [23:0] word);
        return word [23] ? 24'(0 - word) : word;
    endfunction

    // One LED per three bits of level up to a full row
    function automatic logic [7:0] level_bar (input logic [23:0] level);
        int len;
        int lit;
        len = 0;
        while (len < 24 && (level >> len) != 0)
            len++;
        lit = len / 3;
        if (lit > 8)
            lit = 8;
        return 8'((1 << lit) - 1);
    endfunction

    //------------------------------------------------------------
    // Waits and checks

    task automatic note_timeout (input string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic leave_reset ();
        int cycles;
        cycles = 0;
        while (rst && cycles < 100)
        begin
            @(posedge clk);
            cycles++;
        end
        if (rst)
            note_timeout ("reset release");
    endtask

    task automatic wait_frames (input int count);
        int target;
        int cycles;
        @(posedge clk);
        target = tm_frames + count;
        cycles = 0;
        while (tm_frames < target && cycles < count * 4000)
        begin
            @(posedge clk);
            cycles++;
        end
        if (tm_frames < target)
            note_timeout ("TM1638 refresh frames");
    endtask

    task automatic wait_samples (input int count);
        int target;
        int cycles;
        @(posedge clk);
        target = mic_sent + count;
        cycles = 0;
        while (mic_sent < target && cycles < count * 600 + 1000)
        begin
            @(posedge clk);
            cycles++;
        end
        if (mic_sent < target)
            note_timeout ("microphone frames");
    endtask

    // Next word sent opens a fresh peak window
    task automatic align_to_window ();
        int cycles;
        @(posedge clk);
        cycles = 0;
        while (mic_sent % `WINDOW_SAMPLES != 0 && cycles < 20000)
        begin
            @(posedge clk);
            cycles++;
        end
        if (mic_sent % `WINDOW_SAMPLES != 0)
            note_timeout ("window start");
    endtask

    task automatic check_display (input logic [23:0] peak, input string what);
        logic [23:0] shown;
        logic [7:0]  tm_led;
        logic [7:0]  bar;
        @(posedge clk);
        for (int i = 0; i < 6; i++)
            shown [4 * i +: 4] = segments_to_nibble (tm_bytes [2 * i]);
        for (int i = 0; i < 8; i++)
            tm_led [i] = tm_bytes [2 * i + 1] == 8'h01;
        bar = level_bar (peak);
        @(negedge clk);
        assert (shown === peak)
        else
        begin
            errors++;
            $display("FAIL %s tm digits 5..0 got %h expected %h", what, shown, peak);
        end
        assert (tm_led === bar)
        else
        begin
            errors++;
            $display("FAIL %s tm led got %h expected %h", what, tm_led, bar);
        end
        assert (led === bar)
        else
        begin
            errors++;
            $display("FAIL %s led got %h expected %h", what, led, bar);
        end
    endtask

    task automatic check_key_digits (input logic [7:0] code);
        logic [7:0] shown;
        @(posedge clk);
        shown = {segments_to_nibble (tm_bytes [14]), segments_to_nibble (tm_bytes [12])};
        assert (shown === code)
        else
        begin
            errors++;
            $display("FAIL tm digits 7..6 got %h expected %h", shown, code);
        end
    endtask

    //------------------------------------------------------------
    // Tests

    task automatic check_reset_state ();
        wait_frames (1);                        // First frame after reset
        check_display (24'h0, "reset");
        check_key_digits (8'h00);
        @(negedge clk);
        assert (mic_lr === 1'b0)
        else
        begin
            errors++;
            $display("FAIL mic_lr got %h expected %h", mic_lr, 1'b0);
        end
    endtask

    task automatic play_tone (input logic [23:0] word, input string what);
        @(posedge clk);
        mic_idle = word;
        wait_samples (2 * `WINDOW_SAMPLES);
        wait_frames (2);
        check_display (magnitude (word), what);
    endtask

    task automatic find_window_peak ();
        logic [23:0] word;
        logic [23:0] peak;
        peak = '0;
        align_to_window ();
        mic_idle = '0;
        for (int i = 0; i < `WINDOW_SAMPLES; i++)
        begin
            word = 24'($urandom);
            mic_queue.push_back (word);
            if (magnitude (word) > peak)
                peak = magnitude (word);
        end
        wait_samples (`WINDOW_SAMPLES + 1);     // Window closed and published
        wait_frames (2);
        check_display (peak, "random window");
    endtask

    task automatic hold_with_keys ();
        @(posedge clk);
        tm_keys = 8'hA4;
        play_tone (24'h000321, "before hold");
        check_key_digits (8'hA4);
        @(negedge clk);
        key = 2'b10;                            // Button 0 down freezes the level
        @(posedge clk);
        mic_idle = 24'h7ABCDE;
        wait_samples (2 * `WINDOW_SAMPLES);
        wait_frames (2);
        check_display (24'h000321, "hold");
        check_key_digits (8'hA5);               // Board key ORed into bit 0
        @(negedge clk);
        key = 2'b11;
        wait_samples (`WINDOW_SAMPLES + 1);
        wait_frames (2);
        check_display (24'h7ABCDE, "release");
        check_key_digits (8'hA4);
    endtask

    initial
    begin
        seed     = $urandom (14);
        key      = 2'b11;                       // Buttons released
        sw       = 2'b00;
        mic_idle = '0;
        tm_keys  = '0;
        errors   = 0;
        timeouts = 0;

        leave_reset ();
        check_reset_state ();
        if (timeouts == 0)
            play_tone (24'h012345, "positive tone");
        if (timeouts == 0)
            play_tone (24'hFFF100, "negative tone");
        if (timeouts == 0)
            find_window_peak ();
        if (timeouts == 0)
            hold_with_keys ();

        assert_fails = dut0.i_ledkey.bus_check.fail_count;
        $display("Errors: %0d mismatches, %0d timeouts, %0d bus assertion failures",
                 errors, timeouts, assert_fails);
        if (errors + timeouts + assert_fails == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
mic_meter_pkg.sv
display_if.sv
i2s_mic_receiver.sv
level_meter.sv
tm1638_controller.sv
board_top.sv
board_top_assert.sv
tb_clock_gen.sv
tb_board_top.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_board_top \
    -f flist.f -o tb_sim || { echo "Verilator build failed"; exit 1; }

result=$(./obj_dir/tb_sim +verilator+error+limit+1000)
echo "$result"
echo "$result" | grep -qx "TEST PASSED" && exit 0 || exit 1
